// File: logic/rob_pkg.sv
/*
  Reorder buffer sizing
  Depth and index width shared by dispatch, ROB and checker
*/

`default_nettype none

package rob_pkg;

  // ------------------------------
  // Sizing
  // ------------------------------

  // Small on purpose so a full buffer is common
  localparam int ROB_DEPTH = 8;

  // Index into the entry array
  localparam int ROB_IDX_W = $clog2(ROB_DEPTH);

endpackage

`default_nettype wire

// File: logic/exec_pkg.sv
/*
  Execution constants
  Opcode encodings plus data, register and ROB message widths
*/

`default_nettype none

package exec_pkg;

  // ------------------------------
  // Widths
  // ------------------------------

  localparam int DATA_W   = 32;
  localparam int REG_W    = 5;
  localparam int NUM_REGS = 32;
  localparam int OP_W     = 3;

  // ROB message, destination register above the result value
  localparam int MSG_W = REG_W + DATA_W;

  // ------------------------------
  // Opcodes
  // ------------------------------

  // Unlisted codes execute as add
  localparam logic [OP_W-1:0] OP_ADD = 3'd0;
  localparam logic [OP_W-1:0] OP_SUB = 3'd1;
  localparam logic [OP_W-1:0] OP_AND = 3'd2;
  localparam logic [OP_W-1:0] OP_XOR = 3'd3;
  localparam logic [OP_W-1:0] OP_MUL = 3'd4;

endpackage

`default_nettype wire

// File: logic/dispatch_ctrl.sv
/*
  Dispatch control
  Hands out ROB indices in program order, counts entries in flight
  and steers each accepted issue to the ALU or the multiplier
*/

`timescale 1ns/10ps
`default_nettype none

module dispatch_ctrl (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          issue_en,
  input  logic [exec_pkg::OP_W-1:0]     issue_op,
  output logic                          issue_rdy,
  input  logic                          mul_busy,
  input  logic                          commit_en,
  output logic                          alu_go,
  output logic                          mul_go,
  output logic [rob_pkg::ROB_IDX_W-1:0] issue_idx
);

  // ------------------------------
  // Issue acceptance
  // ------------------------------

  logic [rob_pkg::ROB_IDX_W-1:0] tail;
  // One extra bit so a full buffer can be counted
  logic [rob_pkg::ROB_IDX_W:0]   occ;
  logic                          is_mul;
  logic                          rob_space;
  logic                          fire;

  assign is_mul    = (issue_op == exec_pkg::OP_MUL);
  assign rob_space = (occ < (rob_pkg::ROB_IDX_W + 1)'(rob_pkg::ROB_DEPTH));

  // Only one multiply in flight at a time
  assign issue_rdy = rob_space & ~(is_mul & mul_busy);
  assign fire      = issue_en & issue_rdy;

  // Opcode steering
  assign alu_go    = fire & ~is_mul;
  assign mul_go    = fire & is_mul;
  assign issue_idx = tail;

  // ------------------------------
  // Tail pointer
  // ------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      tail <= '0;
    end else if (fire) begin
      // Wrap at depth, not at the power of two
      if (tail == rob_pkg::ROB_IDX_W'(rob_pkg::ROB_DEPTH - 1)) begin
        tail <= '0;
      end else begin
        tail <= tail + 1'b1;
      end
    end
  end

  // ------------------------------
  // Occupancy
  // ------------------------------

  // Issue and commit in one cycle leave the count unchanged
  always_ff @(posedge clk) begin
    if (rst) begin
      occ <= '0;
    end else begin
      case ({fire, commit_en})
        2'b10:   occ <= occ + 1'b1;
        2'b01:   occ <= occ - 1'b1;
        default: occ <= occ;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/mul_unit.sv
/*
  Iterative multiplier
  Shift-add over the set bits of b, so latency follows the data
  Result is held with mul_done until writeback grants it
*/

`timescale 1ns/10ps
`default_nettype none

module mul_unit (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          mul_go,
  input  logic [rob_pkg::ROB_IDX_W-1:0] mul_idx_in,
  input  logic [exec_pkg::REG_W-1:0]    mul_dst_in,
  input  logic [exec_pkg::DATA_W-1:0]   a,
  input  logic [exec_pkg::DATA_W-1:0]   b,
  input  logic                          mul_grant,
  output logic                          mul_busy,
  output logic                          mul_done,
  output logic [rob_pkg::ROB_IDX_W-1:0] mul_idx,
  output logic [exec_pkg::REG_W-1:0]    mul_dst,
  output logic [exec_pkg::DATA_W-1:0]   mul_result
);

  logic                        busy;
  logic                        done;
  logic [exec_pkg::DATA_W-1:0] mcand;
  logic [exec_pkg::DATA_W-1:0] mplier;
  logic [exec_pkg::DATA_W-1:0] acc;

  // ------------------------------
  // One shift-add step
  // ------------------------------

  logic [exec_pkg::DATA_W-1:0] src_mcand;
  logic [exec_pkg::DATA_W-1:0] src_mplier;
  logic [exec_pkg::DATA_W-1:0] src_acc;
  logic [exec_pkg::DATA_W-1:0] step_acc;
  logic                        step;
  logic                        last;

  // First step runs on the operands directly, so b of 0 or 1 takes one cycle
  assign src_mcand  = mul_go ? a  : mcand;
  assign src_mplier = mul_go ? b  : mplier;
  assign src_acc    = mul_go ? '0 : acc;

  // Low 32 bits only, carries out of the top are dropped
  assign step_acc = src_mplier[0] ? src_acc + src_mcand : src_acc;
  assign step     = mul_go | (busy & ~done);
  // Done once nothing is left above the bit just used
  assign last     = (src_mplier[exec_pkg::DATA_W-1:1] == '0);

  // ------------------------------
  // Control
  // ------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= 1'b0;
      done <= 1'b0;
    end else if (mul_go) begin
      busy <= 1'b1;
      done <= last;
    end else if (busy & ~done) begin
      done <= last;
    end else if (done & mul_grant) begin
      // Result taken, unit is free next cycle
      busy <= 1'b0;
      done <= 1'b0;
    end
  end

  // Datapath and tag
  always_ff @(posedge clk) begin
    if (step) begin
      acc    <= step_acc;
      mcand  <= src_mcand << 1;
      mplier <= src_mplier >> 1;
    end
    if (mul_go) begin
      mul_idx <= mul_idx_in;
      mul_dst <= mul_dst_in;
    end
  end

  assign mul_busy   = busy;
  assign mul_done   = done;
  assign mul_result = acc;

endmodule

`default_nettype wire

// File: logic/exec_cluster.sv
/*
  Execution cluster
  One-stage ALU plus the multiplier, sharing a single ROB write port
  ALU results always win the port
*/

`timescale 1ns/10ps
`default_nettype none

module exec_cluster (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          alu_go,
  input  logic                          mul_go,
  input  logic [rob_pkg::ROB_IDX_W-1:0] issue_idx,
  input  logic [exec_pkg::OP_W-1:0]     issue_op,
  input  logic [exec_pkg::REG_W-1:0]    issue_dst,
  input  logic [exec_pkg::DATA_W-1:0]   issue_a,
  input  logic [exec_pkg::DATA_W-1:0]   issue_b,
  output logic                          mul_busy,
  output logic                          ins_en,
  output logic [rob_pkg::ROB_IDX_W-1:0] ins_idx,
  output logic [exec_pkg::MSG_W-1:0]    ins_msg
);

  // ------------------------------
  // ALU
  // ------------------------------

  logic [exec_pkg::DATA_W-1:0] sum;
  logic [exec_pkg::DATA_W-1:0] alu_out;

  assign sum = issue_a + issue_b;

  always_comb begin
    case (issue_op)
      exec_pkg::OP_ADD: alu_out = sum;
      exec_pkg::OP_SUB: alu_out = issue_a - issue_b;
      exec_pkg::OP_AND: alu_out = issue_a & issue_b;
      exec_pkg::OP_XOR: alu_out = issue_a ^ issue_b;
      // Unknown codes fall back to add
      default:          alu_out = sum;
    endcase
  end

  // Result stage, valid one cycle after issue
  logic                          alu_vld;
  logic [rob_pkg::ROB_IDX_W-1:0] alu_idx;
  logic [exec_pkg::REG_W-1:0]    alu_dst;
  logic [exec_pkg::DATA_W-1:0]   alu_res;

  always_ff @(posedge clk) begin
    if (rst) begin
      alu_vld <= 1'b0;
    end else begin
      alu_vld <= alu_go;
    end
  end

  always_ff @(posedge clk) begin
    if (alu_go) begin
      alu_idx <= issue_idx;
      alu_dst <= issue_dst;
      alu_res <= alu_out;
    end
  end

  // ------------------------------
  // Multiplier
  // ------------------------------

  logic                          mul_grant;
  logic                          mul_done;
  logic [rob_pkg::ROB_IDX_W-1:0] mul_idx;
  logic [exec_pkg::REG_W-1:0]    mul_dst;
  logic [exec_pkg::DATA_W-1:0]   mul_result;

  mul_unit u_mul (
    .clk        (clk),
    .rst        (rst),
    .mul_go     (mul_go),
    .mul_idx_in (issue_idx),
    .mul_dst_in (issue_dst),
    .a          (issue_a),
    .b          (issue_b),
    .mul_grant  (mul_grant),
    .mul_busy   (mul_busy),
    .mul_done   (mul_done),
    .mul_idx    (mul_idx),
    .mul_dst    (mul_dst),
    .mul_result (mul_result)
  );

  // ------------------------------
  // Writeback arbitration
  // ------------------------------

  // Multiply waits whenever the ALU stage holds a result
  assign mul_grant = mul_done & ~alu_vld;
  assign ins_en    = alu_vld | mul_done;
  assign ins_idx   = alu_vld ? alu_idx : mul_idx;
  assign ins_msg   = alu_vld ? {alu_dst, alu_res} : {mul_dst, mul_result};

endmodule

`default_nettype wire

// File: logic/reorder_buffer.sv
/*
  Reorder buffer
  Results land at their own index in any order and leave from the head
  strictly in order, with a same-cycle bypass at the head
*/

`timescale 1ns/10ps
`default_nettype none

module reorder_buffer (
  input  logic                          clk,
  input  logic                          rst,

  // ------------------------------
  // Insert side
  // ------------------------------

  input  logic [rob_pkg::ROB_IDX_W-1:0] ins_idx,
  input  logic [exec_pkg::MSG_W-1:0]    ins_msg,
  input  logic                          ins_en,

  // ------------------------------
  // Dequeue side
  // ------------------------------

  output logic [rob_pkg::ROB_IDX_W-1:0] deq_idx,
  output logic [exec_pkg::MSG_W-1:0]    deq_msg,
  input  logic                          deq_en,
  output logic                          deq_rdy
);

  // ------------------------------
  // Entry storage
  // ------------------------------

  logic [rob_pkg::ROB_DEPTH-1:0] valid;
  logic [exec_pkg::MSG_W-1:0]    msg_mem [rob_pkg::ROB_DEPTH];

  logic [rob_pkg::ROB_IDX_W-1:0] head;
  logic [rob_pkg::ROB_IDX_W-1:0] head_next;
  logic                          at_head;
  logic                          bypass;
  logic                          deq_fire;

  // Insert aimed at the entry about to leave
  assign at_head  = (ins_idx == head);
  assign bypass   = ins_en & deq_en & at_head;
  assign deq_fire = deq_en & deq_rdy;

  // Valid bits
  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= '0;
    end else begin
      if (ins_en & ~bypass) begin
        valid[ins_idx] <= 1'b1;
      end
      // Bypassed or not, the head slot is empty afterwards
      if (deq_fire) begin
        valid[head] <= 1'b0;
      end
    end
  end

  // Message payload, skipped when bypassed
  always_ff @(posedge clk) begin
    if (ins_en & ~bypass) begin
      msg_mem[ins_idx] <= ins_msg;
    end
  end

  // ------------------------------
  // Head pointer
  // ------------------------------

  always_comb begin
    if (head == rob_pkg::ROB_IDX_W'(rob_pkg::ROB_DEPTH - 1)) begin
      head_next = '0;
    end else begin
      head_next = head + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      head <= '0;
    end else if (deq_fire) begin
      head <= head_next;
    end
  end

  // ------------------------------
  // Dequeue outputs
  // ------------------------------

  assign deq_rdy = valid[head] | (ins_en & at_head);
  assign deq_msg = bypass ? ins_msg : msg_mem[head];
  assign deq_idx = head;

endmodule

`default_nettype wire

// File: logic/arch_regfile.sv
/*
  Architectural register file
  Written at commit, one combinational read port
*/

`timescale 1ns/10ps
`default_nettype none

module arch_regfile (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        wr_en,
  input  logic [exec_pkg::REG_W-1:0]  wr_addr,
  input  logic [exec_pkg::DATA_W-1:0] wr_data,
  input  logic [exec_pkg::REG_W-1:0]  rd_addr,
  output logic [exec_pkg::DATA_W-1:0] rd_data
);

  logic [exec_pkg::DATA_W-1:0] regs [exec_pkg::NUM_REGS];

  // All registers start at zero
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < exec_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // Write shows up here the cycle after commit
  assign rd_data = regs[rd_addr];

endmodule

`default_nettype wire

// File: logic/ooo_writeback_top.sv
/*
  Writeback and commit top level
  Dispatch, execution, reorder buffer and register file
*/

`timescale 1ns/10ps
`default_nettype none

module ooo_writeback_top (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          issue_en,
  input  logic [exec_pkg::OP_W-1:0]     issue_op,
  input  logic [exec_pkg::REG_W-1:0]    issue_dst,
  input  logic [exec_pkg::DATA_W-1:0]   issue_a,
  input  logic [exec_pkg::DATA_W-1:0]   issue_b,
  output logic                          issue_rdy,
  input  logic                          commit_hold,
  output logic                          commit_en,
  output logic [rob_pkg::ROB_IDX_W-1:0] commit_idx,
  output logic [exec_pkg::REG_W-1:0]    commit_dst,
  output logic [exec_pkg::DATA_W-1:0]   commit_data,
  input  logic [exec_pkg::REG_W-1:0]    rf_raddr,
  output logic [exec_pkg::DATA_W-1:0]   rf_rdata
);

  // ------------------------------
  // Internal nets
  // ------------------------------

  logic                          alu_go;
  logic                          mul_go;
  logic                          mul_busy;
  logic [rob_pkg::ROB_IDX_W-1:0] issue_idx;
  logic                          ins_en;
  logic [rob_pkg::ROB_IDX_W-1:0] ins_idx;
  logic [exec_pkg::MSG_W-1:0]    ins_msg;
  logic                          deq_en;
  logic                          deq_rdy;
  logic [exec_pkg::MSG_W-1:0]    deq_msg;

  // Hold stalls release, commit is the dequeue handshake
  assign deq_en    = ~commit_hold;
  assign commit_en = deq_en & deq_rdy;

  // Message split, register on top
  assign commit_dst  = deq_msg[exec_pkg::MSG_W-1:exec_pkg::DATA_W];
  assign commit_data = deq_msg[exec_pkg::DATA_W-1:0];

  dispatch_ctrl u_dispatch (
    .clk       (clk),
    .rst       (rst),
    .issue_en  (issue_en),
    .issue_op  (issue_op),
    .issue_rdy (issue_rdy),
    .mul_busy  (mul_busy),
    .commit_en (commit_en),
    .alu_go    (alu_go),
    .mul_go    (mul_go),
    .issue_idx (issue_idx)
  );

  exec_cluster u_exec (
    .clk       (clk),
    .rst       (rst),
    .alu_go    (alu_go),
    .mul_go    (mul_go),
    .issue_idx (issue_idx),
    .issue_op  (issue_op),
    .issue_dst (issue_dst),
    .issue_a   (issue_a),
    .issue_b   (issue_b),
    .mul_busy  (mul_busy),
    .ins_en    (ins_en),
    .ins_idx   (ins_idx),
    .ins_msg   (ins_msg)
  );

  reorder_buffer u_rob (
    .clk     (clk),
    .rst     (rst),
    .ins_idx (ins_idx),
    .ins_msg (ins_msg),
    .ins_en  (ins_en),
    .deq_idx (commit_idx),
    .deq_msg (deq_msg),
    .deq_en  (deq_en),
    .deq_rdy (deq_rdy)
  );

  arch_regfile u_rf (
    .clk     (clk),
    .rst     (rst),
    .wr_en   (commit_en),
    .wr_addr (commit_dst),
    .wr_data (commit_data),
    .rd_addr (rf_raddr),
    .rd_data (rf_rdata)
  );

endmodule

`default_nettype wire

// File: dv/commit_checker.sv
/*
  Commit checker
  Models every accepted issue, checks commit order, results and hold,
  keeps a shadow register file and prints the per-test summary
*/

`timescale 1ns/10ps
`default_nettype none

module commit_checker (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          issue_en,
  input  logic                          issue_rdy,
  input  logic [exec_pkg::OP_W-1:0]     issue_op,
  input  logic [exec_pkg::REG_W-1:0]    issue_dst,
  input  logic [exec_pkg::DATA_W-1:0]   issue_a,
  input  logic [exec_pkg::DATA_W-1:0]   issue_b,
  input  logic                          commit_hold,
  input  logic                          commit_en,
  input  logic [rob_pkg::ROB_IDX_W-1:0] commit_idx,
  input  logic [exec_pkg::REG_W-1:0]    commit_dst,
  input  logic [exec_pkg::DATA_W-1:0]   commit_data,
  input  logic [exec_pkg::REG_W-1:0]    rf_raddr,
  input  logic [exec_pkg::DATA_W-1:0]   rf_rdata,
  input  logic                          sweep,
  input  logic                          report_req,
  output int                            issued,
  output int                            pending,
  output int                            error_total,
  output logic                          report_done
);

  // Test slots
  localparam int T_ORDER = 0;
  localparam int T_ALU   = 1;
  localparam int T_MUL   = 2;
  localparam int T_HOLD  = 3;
  localparam int T_RF    = 4;
  localparam int N_TESTS = 5;

  int chk_cnt [N_TESTS];
  int err_cnt [N_TESTS];
  int full_seen;
  int total_chk;

  // In-flight model, one entry per accepted issue, oldest first
  logic [rob_pkg::ROB_IDX_W-1:0] q_idx  [$];
  logic [exec_pkg::REG_W-1:0]    q_dst  [$];
  logic [exec_pkg::DATA_W-1:0]   q_data [$];
  logic                          q_mul  [$];

  logic [exec_pkg::DATA_W-1:0]   shadow [exec_pkg::NUM_REGS];
  logic [rob_pkg::ROB_IDX_W-1:0] exp_idx;
  logic [exec_pkg::REG_W-1:0]    exp_dst;
  logic [exec_pkg::DATA_W-1:0]   exp_data;
  logic                          exp_mul;
  logic                          mul_queued;

  function automatic string test_name(input int t);
    case (t)
      T_ORDER: test_name = "in_order_commit";
      T_ALU:   test_name = "alu_results";
      T_MUL:   test_name = "mul_results";
      T_HOLD:  test_name = "back_pressure";
      default: test_name = "reg_file_sweep";
    endcase
  endfunction

  // Opcode rules, everything unlisted adds
  function automatic logic [exec_pkg::DATA_W-1:0] model_result(
    input logic [exec_pkg::OP_W-1:0]   op,
    input logic [exec_pkg::DATA_W-1:0] a,
    input logic [exec_pkg::DATA_W-1:0] b
  );
    case (op)
      exec_pkg::OP_SUB: model_result = a - b;
      exec_pkg::OP_AND: model_result = a & b;
      exec_pkg::OP_XOR: model_result = a ^ b;
      // Low half of the product
      exec_pkg::OP_MUL: model_result = a * b;
      default:          model_result = a + b;
    endcase
  endfunction

  task automatic compare(input int t, input string what, input logic [31:0] exp_val,
                         input logic [31:0] act_val);
    chk_cnt[t]++;
    if (exp_val !== act_val) begin
      err_cnt[t]++;
      $display("Mismatch %s %s: expected 0x%08h actual 0x%08h",
               test_name(t), what, exp_val, act_val);
    end
  endtask

  task automatic note_failure(input int t, input string what);
    err_cnt[t]++;
    $display("Error in %s: %s", test_name(t), what);
  endtask

  // ------------------------------
  // Sampling at the falling edge
  // ------------------------------

  always @(negedge clk) begin
    if (rst) begin
      q_idx.delete();
      q_dst.delete();
      q_data.delete();
      q_mul.delete();
      for (int r = 0; r < exec_pkg::NUM_REGS; r++) begin
        shadow[r] = '0;
      end
      for (int t = 0; t < N_TESTS; t++) begin
        chk_cnt[t] = 0;
        err_cnt[t] = 0;
      end
      issued      = 0;
      pending     = 0;
      full_seen   = 0;
      error_total = 0;
      report_done = 1'b0;
    end else begin
      // Full buffer, issue must be refused
      if (q_idx.size() == rob_pkg::ROB_DEPTH) begin
        full_seen++;
        chk_cnt[T_HOLD]++;
        if (issue_rdy) begin
          note_failure(T_HOLD, "issue_rdy is high while the ROB is full");
        end
      end

      // Room left and no multiply outstanding, so issue must be accepted
      mul_queued = 1'b0;
      foreach (q_mul[i]) begin
        if (q_mul[i]) begin
          mul_queued = 1'b1;
        end
      end
      if (q_idx.size() < rob_pkg::ROB_DEPTH &&
          (issue_op != exec_pkg::OP_MUL || !mul_queued)) begin
        chk_cnt[T_HOLD]++;
        if (!issue_rdy) begin
          note_failure(T_HOLD, "issue_rdy is low with ROB space and no multiply in flight");
        end
      end

      if (commit_hold) begin
        chk_cnt[T_HOLD]++;
        if (commit_en) begin
          note_failure(T_HOLD, "commit happened while commit_hold was high");
        end
      end

      // Commit against the oldest issue
      if (commit_en) begin
        if (q_idx.size() == 0) begin
          note_failure(T_ORDER, "commit with no operation in flight");
        end else begin
          exp_idx  = q_idx.pop_front();
          exp_dst  = q_dst.pop_front();
          exp_data = q_data.pop_front();
          exp_mul  = q_mul.pop_front();
          compare(T_ORDER, "commit_idx", 32'(exp_idx), 32'(commit_idx));
          compare(T_ORDER, "commit_dst", 32'(exp_dst), 32'(commit_dst));
          compare(exp_mul ? T_MUL : T_ALU, "commit_data", exp_data, commit_data);
          // Shadow file follows the model, last commit wins
          shadow[exp_dst] = exp_data;
        end
      end

      // Accepted issue, index is the issue count modulo depth
      if (issue_en && issue_rdy) begin
        q_idx.push_back(rob_pkg::ROB_IDX_W'(issued % rob_pkg::ROB_DEPTH));
        q_dst.push_back(issue_dst);
        q_data.push_back(model_result(issue_op, issue_a, issue_b));
        q_mul.push_back(issue_op == exec_pkg::OP_MUL);
        issued++;
        if (q_idx.size() > rob_pkg::ROB_DEPTH) begin
          note_failure(T_HOLD, "more operations in flight than ROB entries");
        end
      end

      if (sweep) begin
        compare(T_RF, "rf_rdata", shadow[rf_raddr], rf_rdata);
      end
      pending = q_idx.size();

      // ------------------------------
      // Summary
      // ------------------------------
      if (report_req && !report_done) begin
        if (pending != 0) begin
          note_failure(T_HOLD, "operations were issued but never committed");
        end
        if (full_seen == 0) begin
          note_failure(T_HOLD, "the ROB never filled up");
        end
        total_chk = 0;
        for (int t = 0; t < N_TESTS; t++) begin
          $display("%s: %0d checks, %0d errors", test_name(t), chk_cnt[t], err_cnt[t]);
          total_chk   += chk_cnt[t];
          error_total += err_cnt[t];
        end
        $display("Total: %0d issues, %0d checks, %0d errors", issued, total_chk, error_total);
        report_done = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: dv/tb_top.sv
/*
  Testbench top
  Clock, reset, seeded random issue and hold stimulus,
  drain, register sweep and timeout
*/

`timescale 1ns/10ps
`default_nettype none

module tb_top;

  localparam int NUM_OPS        = 300;
  // Generous per-operation budget, covers holds and drain
  localparam int TIMEOUT_CYCLES = 40 * NUM_OPS;
  // Worst case for a full buffer of back-to-back long multiplies
  localparam int DRAIN_CYCLES   = 40 * rob_pkg::ROB_DEPTH;

  logic                          clk;
  logic                          rst;
  logic                          issue_en;
  logic [exec_pkg::OP_W-1:0]     issue_op;
  logic [exec_pkg::REG_W-1:0]    issue_dst;
  logic [exec_pkg::DATA_W-1:0]   issue_a;
  logic [exec_pkg::DATA_W-1:0]   issue_b;
  logic                          issue_rdy;
  logic                          commit_hold;
  logic                          commit_en;
  logic [rob_pkg::ROB_IDX_W-1:0] commit_idx;
  logic [exec_pkg::REG_W-1:0]    commit_dst;
  logic [exec_pkg::DATA_W-1:0]   commit_data;
  logic [exec_pkg::REG_W-1:0]    rf_raddr;
  logic [exec_pkg::DATA_W-1:0]   rf_rdata;

  logic   sweep;
  logic   report_req;
  logic   report_done;
  int     issued;
  int     pending;
  int     error_total;
  int     cycles;
  int     hold_left;
  int     drain_left;
  int     reg_i;
  integer seed;

  ooo_writeback_top dut (
    .clk         (clk),
    .rst         (rst),
    .issue_en    (issue_en),
    .issue_op    (issue_op),
    .issue_dst   (issue_dst),
    .issue_a     (issue_a),
    .issue_b     (issue_b),
    .issue_rdy   (issue_rdy),
    .commit_hold (commit_hold),
    .commit_en   (commit_en),
    .commit_idx  (commit_idx),
    .commit_dst  (commit_dst),
    .commit_data (commit_data),
    .rf_raddr    (rf_raddr),
    .rf_rdata    (rf_rdata)
  );

  commit_checker chk (
    .clk         (clk),
    .rst         (rst),
    .issue_en    (issue_en),
    .issue_rdy   (issue_rdy),
    .issue_op    (issue_op),
    .issue_dst   (issue_dst),
    .issue_a     (issue_a),
    .issue_b     (issue_b),
    .commit_hold (commit_hold),
    .commit_en   (commit_en),
    .commit_idx  (commit_idx),
    .commit_dst  (commit_dst),
    .commit_data (commit_data),
    .rf_raddr    (rf_raddr),
    .rf_rdata    (rf_rdata),
    .sweep       (sweep),
    .report_req  (report_req),
    .issued      (issued),
    .pending     (pending),
    .error_total (error_total),
    .report_done (report_done)
  );

  // 20 ns period
  always #10 clk = ~clk;

  // ------------------------------
  // Watchdog
  // ------------------------------

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, %0d issued, %0d still in flight",
               cycles, issued, pending);
      $display(">>> FAIL");
      $finish;
    end
  end

  // ------------------------------
  // Stimulus
  // ------------------------------

  // Opcode mix leans on mul, b leans small or zero
  task automatic drive_issue();
    logic [31:0] r;
    logic [31:0] ra;
    logic [31:0] rb;
    int          pick;
    r    = $random(seed);
    ra   = $random(seed);
    rb   = $random(seed);
    pick = int'(r[7:0]) % 10;
    issue_en  = (r[1:0] != 2'b00);
    issue_dst = r[12:8];
    case (pick)
      0, 1:    issue_op = exec_pkg::OP_ADD;
      2:       issue_op = exec_pkg::OP_SUB;
      3:       issue_op = exec_pkg::OP_AND;
      4:       issue_op = exec_pkg::OP_XOR;
      5, 6, 7: issue_op = exec_pkg::OP_MUL;
      // Unused encodings
      8:       issue_op = 3'd5;
      default: issue_op = 3'd7;
    endcase
    case (r[14:13])
      2'd1:    issue_a = ra & 32'h0000_00ff;
      2'd2:    issue_a = ra | 32'h8000_0000;
      default: issue_a = ra;
    endcase
    case (r[16:15])
      2'd0:    issue_b = '0;
      2'd1:    issue_b = rb & 32'h0000_000f;
      2'd2:    issue_b = rb & 32'h0000_0fff;
      default: issue_b = rb;
    endcase
  endtask

  // Short random holds plus occasional long bursts
  task automatic drive_hold();
    logic [31:0] r;
    r = $random(seed);
    if (hold_left > 0) begin
      commit_hold = 1'b1;
      hold_left--;
    end else if (r[7:0] < 8'd6) begin
      commit_hold = 1'b1;
      hold_left   = 8 + int'(r[11:8]);
    end else begin
      commit_hold = (r[15:12] < 4'd2);
    end
  endtask

  initial begin
    seed        = 32'h932c;
    clk         = 1'b0;
    rst         = 1'b1;
    issue_en    = 1'b0;
    issue_op    = exec_pkg::OP_ADD;
    issue_dst   = '0;
    issue_a     = '0;
    issue_b     = '0;
    commit_hold = 1'b0;
    rf_raddr    = '0;
    sweep       = 1'b0;
    report_req  = 1'b0;
    cycles      = 0;
    hold_left   = 0;
    drain_left  = 0;

    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;

    // Random traffic until enough issues have fired
    while (issued < NUM_OPS) begin
      drive_issue();
      drive_hold();
      @(posedge clk);
      #1;
    end

    // Drain everything still in flight, bounded
    issue_en    = 1'b0;
    commit_hold = 1'b0;
    drain_left  = DRAIN_CYCLES;
    while (pending != 0 && drain_left > 0) begin
      @(posedge clk);
      #1;
      drain_left--;
    end

    // Read back every register
    sweep = 1'b1;
    for (reg_i = 0; reg_i < exec_pkg::NUM_REGS; reg_i++) begin
      rf_raddr = exec_pkg::REG_W'(reg_i);
      @(posedge clk);
      #1;
    end
    sweep = 1'b0;

    report_req = 1'b1;
    wait (report_done);
    #1;
    if (error_total == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
logic/rob_pkg.sv
logic/exec_pkg.sv
logic/dispatch_ctrl.sv
logic/mul_unit.sv
logic/exec_cluster.sv
logic/reorder_buffer.sv
logic/arch_regfile.sv
logic/ooo_writeback_top.sv
dv/commit_checker.sv
dv/tb_top.sv

// File: Makefile
# Verilator build and run for the writeback and commit testbench

SRCS := $(shell cat src.f)

obj_dir/Vtb_top: src.f $(SRCS)
	verilator --binary --timing --timescale 1ns/10ps --top-module tb_top -f src.f -o Vtb_top

run: obj_dir/Vtb_top
	./obj_dir/Vtb_top > sim.log
	cat sim.log
	grep -q '^>>> PASS$$' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
